/* cmd_encod_linear_rd.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// expands one read request into N+7 phy command words
// bank and row are fixed for the whole sequence
// first enc_wr 2 cycles after start, enc_done 1 after last
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cmd_encod_linear_rd (
    input  logic                 rst,     // clock
    input  logic                 clk,     // async reset, active high
    input  mcontr_pkg::rd_req_t  req,
    input  logic                 start,
    output mcontr_pkg::phy_cmd_t enc_cmd,
    output logic                 enc_wr,
    output logic                 enc_done
);

    typedef struct packed {
        mcontr_pkg::enc_cmd_e cmd;
        logic [1:0]           pause;      // short pause for nop rows
        logic                 nop;
        logic                 buf_wr;
        logic                 dci;
        logic                 sel;
        logic                 pgnext;     // buffer page advance
        logic                 done;       // last word of the sequence
    } rom_t;

    rom_t                                rom_d;
    rom_t                                rom_r;    // registered rom row
    logic                                rom_v;    // rom_r holds a row to encode
    logic                                gen_run;
    logic [3:0]                          gen_addr;
    logic [mcontr_pkg::NUM_XFER_BITS:0]  left;     // bursts still to read
    logic [mcontr_pkg::COLADDR_NUMBER-4:0] col;
    mcontr_pkg::rd_req_t                 req_r;
    mcontr_pkg::rcw_e                    rcw;
    logic [mcontr_pkg::ADDRESS_NUMBER-1:0] addr;
    logic                                buf_rst;

    always_comb begin
        case (gen_addr)
            4'd0: rom_d = '{cmd: mcontr_pkg::ENC_ACTIVATE, default: '0};
            4'd1: rom_d = '{cmd: mcontr_pkg::ENC_NOP, pause: 2'd1, default: '0};
            4'd2, 4'd3: rom_d = '{cmd: mcontr_pkg::ENC_READ, nop: 1'b1, buf_wr: 1'b1,
                                  dci: 1'b1, sel: 1'b1, default: '0}; // 3 is the loop row
            4'd4: rom_d = '{cmd: mcontr_pkg::ENC_NOP, pause: 2'd1, dci: 1'b1, sel: 1'b1,
                            default: '0};
            4'd5: rom_d = '{cmd: mcontr_pkg::ENC_NOP, dci: 1'b1, sel: 1'b1, pgnext: 1'b1,
                            default: '0};
            4'd6: rom_d = '{cmd: mcontr_pkg::ENC_PRECHARGE, dci: 1'b1, default: '0};
            4'd7: rom_d = '{cmd: mcontr_pkg::ENC_NOP, pause: 2'd2, dci: 1'b1, default: '0};
            4'd8: rom_d = '{cmd: mcontr_pkg::ENC_NOP, done: 1'b1, default: '0};
            default: rom_d = '{cmd: mcontr_pkg::ENC_NOP, default: '0};
        endcase
    end

    always_comb begin
        case (rom_r.cmd)
            mcontr_pkg::ENC_READ:      rcw = mcontr_pkg::RCW_READ;
            mcontr_pkg::ENC_PRECHARGE: rcw = mcontr_pkg::RCW_PRECHARGE;
            mcontr_pkg::ENC_ACTIVATE:  rcw = mcontr_pkg::RCW_ACTIVATE;
            default:                   rcw = mcontr_pkg::RCW_NOP;
        endcase
    end

    // activate/precharge take the row, reads the column in 8-word steps
    assign addr    = rom_r.cmd[1] ? req_r.row : {5'b0, col, 3'b0};
    assign buf_rst = rom_r.pgnext & ~req_r.skip_next_page;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            gen_run  <= 1'b0;
            gen_addr <= '0;
            left     <= '0;
            rom_r    <= '{cmd: mcontr_pkg::ENC_NOP, default: '0};
            rom_v    <= 1'b0;
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end else begin
            if (start)
                gen_run <= 1'b1;
            else if (gen_run && gen_addr == 4'd8)
                gen_run <= 1'b0;            // last row fetched
            if (start | gen_run) begin
                rom_r <= rom_d;
                if (gen_addr == 4'd2 || gen_addr == 4'd3)
                    gen_addr <= (left[mcontr_pkg::NUM_XFER_BITS:1] != '0) ? 4'd3 : 4'd4;
                else if (gen_addr == 4'd8)
                    gen_addr <= 4'd0;
                else
                    gen_addr <= gen_addr + 4'd1;
            end
            if (start)
                left <= {(req.num128 == '0), req.num128}; // zero count gives 64
            else if (gen_run && (gen_addr == 4'd2 || gen_addr == 4'd3))
                left <= left - 1'b1;
            rom_v    <= start | gen_run;
            enc_wr   <= rom_v;
            enc_done <= enc_wr & ~rom_v;    // one cycle after the last write
        end
    end

    always_ff @(posedge rst) begin
        if (start) begin
            req_r <= req;
            col   <= req.start_col;
        end else if (rom_v && rom_r.cmd == mcontr_pkg::ENC_READ) begin
            col <= col + 1'b1;              // next burst column
        end
        if (rom_r.cmd == mcontr_pkg::ENC_NOP)
            enc_cmd <= mcontr_pkg::encode_skip(
                {{(mcontr_pkg::CMD_PAUSE_BITS-2){1'b0}}, rom_r.pause}, rom_r.done,
                req_r.bank, 1'b0, 1'b0, rom_r.sel, 1'b0, 1'b0, 1'b0, rom_r.dci,
                rom_r.buf_wr, 1'b0, buf_rst);
        else
            enc_cmd <= mcontr_pkg::encode_cmd(
                addr, req_r.bank, rcw, 1'b0, 1'b0, rom_r.sel, 1'b0, 1'b0, 1'b0,
                rom_r.dci, rom_r.buf_wr, 1'b0, rom_r.nop, buf_rst);
    end

endmodule

/* cmd_seq_mem.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 128-word command store, write pointer is internal
// read data is registered, 1 cycle after rd_addr
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cmd_seq_mem (
    input  logic                             rst,     // clock
    input  logic                             clk,     // async reset, active high
    input  logic                             wr_rst,  // restart at word 0
    input  logic                             wr_en,
    input  mcontr_pkg::phy_cmd_t             wr_data,
    input  logic [mcontr_pkg::SEQ_MEM_AW-1:0] rd_addr,
    output mcontr_pkg::phy_cmd_t             rd_data
);

    mcontr_pkg::phy_cmd_t                mem [2**mcontr_pkg::SEQ_MEM_AW];
    logic [mcontr_pkg::SEQ_MEM_AW-1:0]   wr_ptr;

    always_ff @(posedge rst or posedge clk) begin
        if (clk)
            wr_ptr <= '0;
        else if (wr_rst)
            wr_ptr <= '0;
        else if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;        // wraps past 127
    end

    always_ff @(posedge rst) begin
        if (wr_en)
            mem[wr_ptr] <= wr_data;
        rd_data <= mem[rd_addr];
    end

endmodule

/* cmd_seq_player.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// plays stored words from address 0 to the phy port
// phy_cmd/phy_valid hold while phy_ready is low
// stops on the word carrying the done flag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cmd_seq_player (
    input  logic                              rst,      // clock
    input  logic                              clk,      // async reset, active high
    input  logic                              run,      // sequence is in memory
    output logic [mcontr_pkg::SEQ_MEM_AW-1:0] rd_addr,
    input  mcontr_pkg::phy_cmd_t              rd_data,
    output mcontr_pkg::phy_cmd_t              phy_cmd,
    output logic                              phy_valid,
    input  logic                              phy_ready,
    output logic                              seq_done
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,                              // memory read in flight
        ISSUE,                              // word on the port
        WAIT,                               // pause or extra nop
        DONE
    } state_e;

    state_e                                 state;
    logic [mcontr_pkg::CMD_PAUSE_BITS-1:0]  cnt;
    logic [mcontr_pkg::CMD_PAUSE_BITS-1:0]  wait_len;
    logic                                   is_pause;
    logic                                   is_done;
    logic                                   xfer;

    assign is_pause = (rd_data.rcw == mcontr_pkg::RCW_NOP);
    assign is_done  = is_pause & rd_data.addr[mcontr_pkg::CMD_DONE_BIT];
    assign wait_len = is_pause ? rd_data.addr[mcontr_pkg::CMD_PAUSE_BITS-1:0]
                               : {{(mcontr_pkg::CMD_PAUSE_BITS-1){1'b0}}, rd_data.nop};
    assign phy_valid = (state == ISSUE);
    assign phy_cmd   = rd_data;             // rd_addr is stable in ISSUE
    assign xfer      = phy_valid & phy_ready;
    assign seq_done  = (state == DONE);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state   <= IDLE;
            rd_addr <= '0;
            cnt     <= '0;
        end else begin
            case (state)
                IDLE: if (run) begin
                    state   <= FETCH;
                    rd_addr <= '0;
                end
                FETCH: state <= ISSUE;
                ISSUE: if (xfer) begin
                    rd_addr <= rd_addr + 1'b1;
                    cnt     <= wait_len;
                    if (is_done)
                        state <= DONE;
                    else if (wait_len != '0)
                        state <= WAIT;
                    else
                        state <= FETCH;
                end
                WAIT: begin
                    cnt <= cnt - 1'b1;
                    if (cnt[mcontr_pkg::CMD_PAUSE_BITS-1:1] == '0)
                        state <= FETCH;     // last counted cycle
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* mcontr_linear_rd_top.f */
mcontr_pkg.sv
mcontr_wb_regs.sv
cmd_encod_linear_rd.sv
cmd_seq_mem.sv
cmd_seq_player.sv
mcontr_linear_rd_top.sv
tb_clk_gen.sv
tb_mcontr_linear_rd.sv

/* mcontr_linear_rd_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read sequence generator, wishbone in, phy commands out
// one request at a time, up to one page per request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mcontr_linear_rd_top (
    input  logic                 rst,        // clock
    input  logic                 clk,        // async reset, active high
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [1:0]           wb_adr,
    input  logic [31:0]          wb_dat_i,
    output logic [31:0]          wb_dat_o,
    output logic                 wb_ack,
    output mcontr_pkg::phy_cmd_t phy_cmd,
    output logic                 phy_valid,
    input  logic                 phy_ready
);

    mcontr_pkg::rd_req_t               req;
    logic                              start;
    mcontr_pkg::phy_cmd_t              enc_cmd;
    logic                              enc_wr;
    logic                              enc_done;
    logic [mcontr_pkg::SEQ_MEM_AW-1:0] rd_addr;
    mcontr_pkg::phy_cmd_t              rd_data;
    logic                              seq_done;

    mcontr_wb_regs u_regs (
        .rst(rst), .clk(clk),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .seq_done(seq_done), .req(req), .start(start)
    );

    cmd_encod_linear_rd u_enc (
        .rst(rst), .clk(clk), .req(req), .start(start),
        .enc_cmd(enc_cmd), .enc_wr(enc_wr), .enc_done(enc_done)
    );

    cmd_seq_mem u_mem (
        .rst(rst), .clk(clk), .wr_rst(start), .wr_en(enc_wr), // start rewinds the write side
        .wr_data(enc_cmd), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    cmd_seq_player u_player (
        .rst(rst), .clk(clk), .run(enc_done), .rd_addr(rd_addr), .rd_data(rd_data),
        .phy_cmd(phy_cmd), .phy_valid(phy_valid), .phy_ready(phy_ready),
        .seq_done(seq_done)
    );

endmodule

/* mcontr_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared sizes, codes and word layouts for the DDR3 read
// sequence path. rcw codes are positive logic
// pause words carry the count in addr[9:0] and done in addr[10]
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mcontr_pkg;

    localparam int ADDRESS_NUMBER = 15;     // row address width
    localparam int COLADDR_NUMBER = 10;     // column width
    localparam int NUM_XFER_BITS  = 6;      // burst count field, 0 means 64
    localparam int CMD_PAUSE_BITS = 10;     // pause field in a NOP word
    localparam int CMD_DONE_BIT   = 10;     // done flag position in addr
    localparam int SEQ_MEM_AW     = 7;      // 128 command words

    typedef enum logic [1:0] {
        ENC_NOP       = 2'd0,
        ENC_READ      = 2'd1,
        ENC_PRECHARGE = 2'd2,
        ENC_ACTIVATE  = 2'd3
    } enc_cmd_e;                            // local ROM command codes

    typedef enum logic [2:0] {
        RCW_NOP       = 3'd0,
        RCW_READ      = 3'd2,
        RCW_ACTIVATE  = 3'd4,
        RCW_PRECHARGE = 3'd5
    } rcw_e;                                // ras/cas/we as sent to the phy

    typedef struct packed {
        logic [ADDRESS_NUMBER-1:0] addr;    // row, column or pause/done
        logic [2:0]                bank;
        logic [2:0]                rcw;
        logic                      odt_en;
        logic                      cke;
        logic                      sel;     // half-cycle select
        logic                      dq_en;
        logic                      dqs_en;
        logic                      dqs_toggle;
        logic                      dci;
        logic                      buf_wr;  // read data goes to the buffer
        logic                      buf_rd;
        logic                      nop;     // one nop cycle after this word
        logic                      buf_rst; // buffer moves to next page
    } phy_cmd_t;

    typedef struct packed {
        logic [2:0]                  bank;
        logic [ADDRESS_NUMBER-1:0]   row;
        logic [COLADDR_NUMBER-4:0]   start_col;      // in 8-word bursts
        logic [NUM_XFER_BITS-1:0]    num128;
        logic                        skip_next_page; // keep buffer page
    } rd_req_t;

    function automatic phy_cmd_t encode_cmd(
        input logic [ADDRESS_NUMBER-1:0] addr,
        input logic [2:0]                bank,
        input logic [2:0]                rcw,
        input logic                      odt_en,
        input logic                      cke,
        input logic                      sel,
        input logic                      dq_en,
        input logic                      dqs_en,
        input logic                      dqs_toggle,
        input logic                      dci,
        input logic                      buf_wr,
        input logic                      buf_rd,
        input logic                      nop,
        input logic                      buf_rst
    );
        encode_cmd = '{addr, bank, rcw, odt_en, cke, sel, dq_en, dqs_en,
                       dqs_toggle, dci, buf_wr, buf_rd, nop, buf_rst};
    endfunction

    function automatic phy_cmd_t encode_skip(
        input logic [CMD_PAUSE_BITS-1:0] skip,
        input logic                      done,
        input logic [2:0]                bank,
        input logic                      odt_en,
        input logic                      cke,
        input logic                      sel,
        input logic                      dq_en,
        input logic                      dqs_en,
        input logic                      dqs_toggle,
        input logic                      dci,
        input logic                      buf_wr,
        input logic                      buf_rd,
        input logic                      buf_rst
    );
        encode_skip = encode_cmd({{(14-CMD_DONE_BIT){1'b0}}, done, skip}, bank, RCW_NOP,
                                 odt_en, cke, sel, dq_en, dqs_en, dqs_toggle, dci,
                                 buf_wr, buf_rd, 1'b0, buf_rst); // pause words never add a nop
    endfunction

endpackage

/* mcontr_wb_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic slave, ack one cycle after strobe
// no wait states. start written while busy is dropped
// done is sticky until the next accepted start
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mcontr_wb_regs (
    input  logic                rst,        // clock
    input  logic                clk,        // async reset, active high
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [1:0]          wb_adr,
    input  logic [31:0]         wb_dat_i,
    output logic [31:0]         wb_dat_o,
    output logic                wb_ack,
    input  logic                seq_done,   // player finished the sequence
    output mcontr_pkg::rd_req_t req,
    output logic                start       // one-cycle pulse to the encoder
);

    logic        acc;                        // access accepted this cycle
    logic        busy;
    logic        done;
    logic [31:0] rd_mux;

    assign acc = wb_cyc & wb_stb & ~wb_ack;  // ~ack keeps ack one cycle wide

    always_comb begin
        case (wb_adr)
            2'd0:    rd_mux = {13'b0, req.bank, 1'b0, req.row};
            2'd1:    rd_mux = {15'b0, req.skip_next_page, 2'b0, req.num128, 1'b0, req.start_col};
            2'd3:    rd_mux = {30'b0, done, busy};
            default: rd_mux = '0;           // control reads as zero
        endcase
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
            busy   <= 1'b0;
            done   <= 1'b0;
        end else begin
            wb_ack <= acc;
            start  <= acc & wb_we & (wb_adr == 2'd2) & wb_dat_i[0] & ~busy;
            if (start)
                busy <= 1'b1;
            else if (seq_done)
                busy <= 1'b0;
            if (start)
                done <= 1'b0;               // cleared by a new run
            else if (seq_done)
                done <= 1'b1;
        end
    end

    always_ff @(posedge rst) begin
        if (acc & wb_we & (wb_adr == 2'd0)) begin
            req.row  <= wb_dat_i[14:0];
            req.bank <= wb_dat_i[18:16];
        end
        if (acc & wb_we & (wb_adr == 2'd1)) begin
            req.start_col      <= wb_dat_i[6:0];
            req.num128         <= wb_dat_i[13:8];
            req.skip_next_page <= wb_dat_i[16];
        end
        if (acc & ~wb_we)
            wb_dat_o <= rd_mux;             // valid with ack
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mcontr_linear_rd \
    -f mcontr_linear_rd_top.f -o tb_sim || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

/* tb_clk_gen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock on rst (20 ns), reset on clk
// reset is high for the first 2 rising edges
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clk_gen (
    output logic rst,                       // clock
    output logic clk                        // async reset, active high
);

    initial begin
        rst = 1'b0;
        forever #10 rst = ~rst;             // 20 ns period
    end

    initial begin
        clk = 1'b1;
        repeat (2) @(posedge rst);
        #1 clk = 1'b0;                      // release just after the 2nd edge
    end

endmodule

/* tb_mcontr_linear_rd.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the read sequence generator
// inputs change 1 ns after the rising edge, PHY words sampled
// on the falling edge. stops at the first mismatch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_mcontr_linear_rd;

    localparam int REQ_CYCLES  = 71 * 4 + 200;        // worst request, in clocks
    localparam int WATCHDOG_NS = 12 * REQ_CYCLES * 20; // 12 requests

    logic                 rst;                       // clock
    logic                 clk;                       // reset
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [1:0]           wb_adr;
    logic [31:0]          wb_dat_i;
    logic [31:0]          wb_dat_o;
    logic                 wb_ack;
    mcontr_pkg::phy_cmd_t phy_cmd;
    logic                 phy_valid;
    logic                 phy_ready;
    logic                 bp_en;                     // random back-pressure on
    mcontr_pkg::phy_cmd_t exp_q[$];                  // words still expected
    int                   word_idx;

    tb_clk_gen u_clk_gen (.rst(rst), .clk(clk));

    mcontr_linear_rd_top uut (
        .rst(rst), .clk(clk),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .phy_cmd(phy_cmd), .phy_valid(phy_valid), .phy_ready(phy_ready)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t ns: %s, got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int n;
        @(posedge rst);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        n        = 0;
        do begin
            @(posedge rst);
            #1;
            n++;
            if (n > 4)
                fail_run("ERROR: no Wishbone ack from the register block");
        end while (!wb_ack);
        check(n, 1, "ack latency");                 // no wait states
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, data);
    endtask

    // reference word idx of the sequence for request r
    function automatic mcontr_pkg::phy_cmd_t expected_word(input mcontr_pkg::rd_req_t r,
                                                           input int idx);
        mcontr_pkg::phy_cmd_t w;
        int                   n;
        logic [6:0]           col;
        n      = (r.num128 == '0) ? 64 : int'(r.num128);
        col    = r.start_col + 7'(idx - 2);           // column wraps inside the page
        w      = '0;
        w.bank = r.bank;                              // bank rides on every word
        w.rcw  = mcontr_pkg::RCW_NOP;
        if (idx == 0) begin
            w.rcw  = mcontr_pkg::RCW_ACTIVATE;
            w.addr = r.row;
        end else if (idx == 1) begin
            w.addr = 15'd1;                           // pause 1 after activate
        end else if (idx < n + 2) begin
            w.rcw    = mcontr_pkg::RCW_READ;
            w.addr   = {5'b0, col, 3'b0};             // 8 words per burst
            w.nop    = 1'b1;
            w.buf_wr = 1'b1;
            w.dci    = 1'b1;
            w.sel    = 1'b1;
        end else if (idx == n + 2) begin
            w.addr = 15'd1;
            w.dci  = 1'b1;
            w.sel  = 1'b1;
        end else if (idx == n + 3) begin
            w.dci     = 1'b1;
            w.sel     = 1'b1;
            w.buf_rst = ~r.skip_next_page;            // page-next word
        end else if (idx == n + 4) begin
            w.rcw  = mcontr_pkg::RCW_PRECHARGE;
            w.addr = r.row;
            w.dci  = 1'b1;
        end else if (idx == n + 5) begin
            w.addr = 15'd2;
            w.dci  = 1'b1;
        end else begin
            w.addr[mcontr_pkg::CMD_DONE_BIT] = 1'b1;  // last word, pause 0
        end
        return w;
    endfunction

    function automatic mcontr_pkg::rd_req_t random_req();
        mcontr_pkg::rd_req_t r;
        r.bank           = 3'($urandom);
        r.row            = 15'($urandom);
        r.start_col      = 7'($urandom);
        r.num128         = 6'($urandom);
        r.skip_next_page = 1'($urandom);
        return r;
    endfunction

    task automatic run_request(input mcontr_pkg::rd_req_t r, input logic busy_test);
        int          n;
        int          i;
        int          cycles;
        logic [31:0] stat;
        n        = (r.num128 == '0) ? 64 : int'(r.num128);
        word_idx = 0;
        for (i = 0; i < n + 7; i++)
            exp_q.push_back(expected_word(r, i));
        wb_write(2'd0, {13'b0, r.bank, 1'b0, r.row});
        wb_write(2'd1, {15'b0, r.skip_next_page, 2'b0, r.num128, 1'b0, r.start_col});
        wb_write(2'd2, 32'h1);
        if (busy_test) begin
            wb_read(2'd3, stat);
            check(stat, 32'h1, "busy after start");   // done cleared by the start
            wb_write(2'd2, 32'h1);                    // dropped while busy
            wb_read(2'd3, stat);
            check(stat, 32'h1, "busy after start while busy");
        end
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge rst);
            cycles++;
            if (cycles > REQ_CYCLES)
                fail_run("ERROR: PHY sequence did not complete in time");
        end
        cycles = 0;
        do begin
            wb_read(2'd3, stat);
            cycles++;
            if (cycles > 10)
                fail_run("ERROR: status stayed busy after the sequence");
        end while (stat[0]);
        check(stat, 32'h2, "status done after request");
    endtask

    // words transfer at the next rising edge
    always @(negedge rst) begin
        if (phy_valid && phy_ready) begin
            if (exp_q.size() == 0)
                fail_run($sformatf("ERROR: unexpected PHY word %h at %0t ns", phy_cmd, $time));
            check(phy_cmd, exp_q.pop_front(), $sformatf("PHY word %0d", word_idx));
            word_idx++;
        end
    end

    always @(posedge rst) begin
        #1;
        phy_ready = bp_en ? ($urandom_range(9, 0) >= 4) : 1'b1;  // low about 40%
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("ERROR: watchdog timeout, the run did not finish");
    end

    initial begin
        logic [31:0]         rdata;
        mcontr_pkg::rd_req_t r;
        int                  i;
        void'($urandom(32'h1542106e));
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 2'd0;
        wb_dat_i  = 32'h0;
        phy_ready = 1'b1;
        bp_en     = 1'b0;
        word_idx  = 0;
        @(negedge clk);
        repeat (2) @(posedge rst);
        wb_read(2'd3, rdata);
        check(rdata, 32'h0, "status after reset");
        wb_write(2'd0, 32'hFFFF_FFFF);
        wb_read(2'd0, rdata);
        check(rdata, 32'h0007_7FFF, "row/bank readback");  // unused bits read 0
        wb_write(2'd1, 32'hFFFF_FFFF);
        wb_read(2'd1, rdata);
        check(rdata, 32'h0001_3F7F, "column/count readback");
        wb_write(2'd0, 32'h0002_5A5A);
        wb_read(2'd0, rdata);
        check(rdata, 32'h0002_5A5A, "row/bank readback");
        wb_read(2'd2, rdata);
        check(rdata, 32'h0, "control reads zero");
        for (i = 0; i < 8; i++)
            run_request(random_req(), 1'b0);
        r                = random_req();
        r.num128         = 6'd1;                      // single read
        r.skip_next_page = 1'b1;
        run_request(r, 1'b0);
        r                = random_req();
        r.num128         = 6'd0;                      // full 64 reads
        r.skip_next_page = 1'b0;
        run_request(r, 1'b0);
        bp_en = 1'b1;
        run_request(random_req(), 1'b0);
        bp_en    = 1'b0;
        r        = random_req();
        r.num128 = 6'd0;                              // long enough to poll busy
        run_request(r, 1'b1);
        repeat (200) @(posedge rst);                  // any second sequence shows up here
        $display("Test completed successfully");
        $finish;
    end

endmodule
